// ==== filelist.f ====
source/mips_pkg.sv
source/stage_if.sv
source/rtype_decoder.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/rtype_core.sv
bench/rtype_core_sva.sv
bench/rtype_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the R-type core testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rtype_core_tb -f filelist.f -o sim_rtype_core

# The log decides pass or fail, so a non-zero exit of the binary is tolerated here.
./obj_dir/sim_rtype_core > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
    exit 0
else
    exit 1
fi

// ==== bench/rtype_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtype_core_tb import mips_pkg::*; ();

    typedef struct packed {
        logic        wb_valid;
        logic [4:0]  wb_reg;
        logic [31:0] wb_data;
        logic        redirect_valid;
        logic [31:0] redirect_pc;
        logic        exc_valid;
        exc_t        exc_code;
    } expect_t;

    typedef struct packed {
        logic        load_en;
        logic [4:0]  load_reg;
        logic [31:0] load_data;
        logic [31:0] word;
        logic [3:0]  gap;
    } entry_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic        load_valid;
    logic [4:0]  load_reg;
    logic [31:0] load_data;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        exc_valid;
    exc_t        exc_code;

    logic [31:0] regs [32];
    logic [31:0] hi = 32'd0;
    logic [31:0] lo = 32'd0;
    logic [31:0] next_pc = 32'h0040_0000;
    logic        squash_next = 1'b0;
    logic [31:0] lfsr_state = 32'h1913;
    expect_t     exp_q [$];
    entry_t      table_q [$];
    int          checks = 0;
    int          errors = 0;

    rtype_core uut (.*);

    bind rtype_core rtype_core_sva u_sva (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    task automatic random_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i] = lfsr_state[0];
        end
    endtask

    function automatic logic [31:0] encode(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sh,
                                           input logic [5:0] funct);
        return {6'd0, rs, rt, rd, sh, funct};
    endfunction

    task automatic add_instr(input logic [31:0] word, input logic [3:0] gap);
        table_q.push_back({1'b0, 5'd0, 32'd0, word, gap});
    endtask

    task automatic add_load(input logic [4:0] r, input logic [31:0] d,
                            input logic [31:0] word, input logic [3:0] gap);
        table_q.push_back({1'b1, r, d, word, gap});
    endtask

    // Reference model of one instruction; updates the model state.
    task automatic model_instr(input logic [31:0] w, input logic [31:0] p, output expect_t e);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [63:0] prod;
        logic        write;
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        sh = w[10:6];
        a = regs[rs];
        b = regs[rt];
        v = 32'd0;
        write = 1'b0;
        e = '0;
        e.exc_code = EXC_NONE;
        if (w[31:26] != 6'd0) begin
            e.exc_valid = 1'b1;
            e.exc_code = EXC_RESERVED;
        end else begin
            case (w[5:0])
                FUNCT_SLL: begin
                    v = b << sh;
                    write = 1'b1;
                end
                FUNCT_SRL: begin
                    if (w[21] && sh != 5'd0) v = (b >> sh) | (b << (32 - sh));
                    else v = b >> sh;
                    write = 1'b1;
                end
                FUNCT_JR: begin
                    e.redirect_valid = 1'b1;
                    e.redirect_pc = a;
                end
                FUNCT_JALR: begin
                    e.redirect_valid = 1'b1;
                    e.redirect_pc = a;
                    v = p + 32'd8;
                    write = 1'b1;
                end
                FUNCT_MOVZ: begin
                    v = a;
                    write = (b == 32'd0);
                end
                FUNCT_MOVN: begin
                    v = a;
                    write = (b != 32'd0);
                end
                FUNCT_SYSCALL: begin
                    e.exc_valid = 1'b1;
                    e.exc_code = EXC_SYSCALL;
                end
                FUNCT_MFHI: begin
                    v = hi;
                    write = 1'b1;
                end
                FUNCT_MFLO: begin
                    v = lo;
                    write = 1'b1;
                end
                FUNCT_MTHI: hi = a;
                FUNCT_MTLO: lo = a;
                FUNCT_MULT: begin
                    prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                    hi = prod[63:32];
                    lo = prod[31:0];
                end
                FUNCT_MULTU: begin
                    prod = {32'd0, a} * {32'd0, b};
                    hi = prod[63:32];
                    lo = prod[31:0];
                end
                FUNCT_ADDU: begin
                    v = a + b;
                    write = 1'b1;
                end
                FUNCT_SUBU: begin
                    v = a - b;
                    write = 1'b1;
                end
                FUNCT_AND: begin
                    v = a & b;
                    write = 1'b1;
                end
                FUNCT_OR: begin
                    v = a | b;
                    write = 1'b1;
                end
                FUNCT_XOR: begin
                    v = a ^ b;
                    write = 1'b1;
                end
                FUNCT_NOR: begin
                    v = ~(a | b);
                    write = 1'b1;
                end
                FUNCT_SLT: begin
                    v = {31'd0, $signed(a) < $signed(b)};
                    write = 1'b1;
                end
                FUNCT_SLTU: begin
                    v = {31'd0, a < b};
                    write = 1'b1;
                end
                default: begin
                    e.exc_valid = 1'b1;
                    e.exc_code = EXC_RESERVED;
                end
            endcase
        end
        if (write && rd != 5'd0) begin
            regs[rd] = v;
            e.wb_valid = 1'b1;
            e.wb_reg = rd;
            e.wb_data = v;
        end
    endtask

    task automatic check_slot(input expect_t e);
        checks++;
        assert (wb_valid === e.wb_valid) else begin
            $display("Fail wb_valid: got %h expected %h", wb_valid, e.wb_valid);
            errors++;
        end
        if (e.wb_valid) begin
            assert (wb_reg === e.wb_reg && wb_data === e.wb_data) else begin
                $display("Fail wb_reg/wb_data: got %h/%h expected %h/%h",
                         wb_reg, wb_data, e.wb_reg, e.wb_data);
                errors++;
            end
        end
        assert (redirect_valid === e.redirect_valid) else begin
            $display("Fail redirect_valid: got %h expected %h", redirect_valid, e.redirect_valid);
            errors++;
        end
        if (e.redirect_valid) begin
            assert (redirect_pc === e.redirect_pc) else begin
                $display("Fail redirect_pc: got %h expected %h", redirect_pc, e.redirect_pc);
                errors++;
            end
        end
        assert (exc_valid === e.exc_valid && exc_code === e.exc_code) else begin
            $display("Fail exc_valid/exc_code: got %h/%h expected %h/%h",
                     exc_valid, exc_code, e.exc_valid, e.exc_code);
            errors++;
        end
    endtask

    // One input slot; outputs of the slot two falling edges back are checked first.
    task automatic run_slot(input logic ld_en, input logic [4:0] ld_reg,
                            input logic [31:0] ld_data, input logic in_en,
                            input logic [31:0] word);
        expect_t e;
        logic    dropped;
        @(negedge clk);
        if (exp_q.size() == 2) check_slot(exp_q.pop_front());
        load_valid = ld_en;
        load_reg = ld_reg;
        load_data = ld_data;
        instr_valid = in_en;
        instruction = word;
        pc = next_pc;
        e = '0;
        e.exc_code = EXC_NONE;
        if (ld_en && ld_reg != 5'd0) regs[ld_reg] = ld_data;
        dropped = squash_next;
        squash_next = 1'b0;
        if (in_en) begin
            if (!dropped) begin
                model_instr(word, next_pc, e);
                squash_next = e.exc_valid;
            end
            next_pc = next_pc + 32'd4;
        end
        exp_q.push_back(e);
    endtask

    task automatic build_table();
        add_instr(encode(1, 2, 3, 0, FUNCT_ADDU), 0);
        add_instr(encode(1, 2, 4, 0, FUNCT_SUBU), 0);
        add_instr(encode(1, 2, 5, 0, FUNCT_AND), 0);
        add_instr(encode(1, 2, 6, 0, FUNCT_OR), 0);
        add_instr(encode(1, 2, 7, 0, FUNCT_XOR), 0);
        add_instr(encode(1, 2, 8, 0, FUNCT_NOR), 0);
        add_instr(encode(1, 2, 9, 0, FUNCT_SLT), 0);
        add_instr(encode(2, 1, 10, 0, FUNCT_SLTU), 0);
        add_instr(encode(0, 2, 11, 5, FUNCT_SLL), 0);
        add_instr(encode(0, 2, 12, 7, FUNCT_SRL), 0);
        add_instr(encode(1, 2, 13, 9, FUNCT_SRL), 0);
        add_instr(encode(1, 3, 14, 0, FUNCT_SRL), 2);
        // Dependent chain, then a load colliding with a writeback to r18.
        add_instr(encode(3, 4, 15, 0, FUNCT_ADDU), 0);
        add_instr(encode(15, 1, 16, 0, FUNCT_SUBU), 0);
        add_instr(encode(16, 15, 17, 0, FUNCT_XOR), 0);
        add_instr(encode(1, 2, 18, 0, FUNCT_ADDU), 0);
        add_instr(encode(5, 6, 19, 0, FUNCT_OR), 0);
        add_load(18, 32'hCAFE_F00D, encode(18, 0, 20, 0, FUNCT_OR), 0);
        add_instr(encode(18, 0, 21, 0, FUNCT_ADDU), 2);
        add_instr(encode(1, 0, 22, 0, FUNCT_MOVZ), 0);
        add_instr(encode(1, 2, 23, 0, FUNCT_MOVZ), 0);
        add_instr(encode(1, 2, 24, 0, FUNCT_MOVN), 0);
        add_instr(encode(1, 0, 25, 0, FUNCT_MOVN), 0);
        add_instr(encode(1, 2, 0, 0, FUNCT_ADDU), 1);
        add_instr(encode(1, 0, 0, 0, FUNCT_MTHI), 0);
        add_instr(encode(2, 0, 0, 0, FUNCT_MTLO), 0);
        add_instr(encode(0, 0, 26, 0, FUNCT_MFHI), 0);
        add_instr(encode(0, 0, 27, 0, FUNCT_MFLO), 0);
        add_instr(encode(1, 2, 0, 0, FUNCT_MULT), 0);
        add_instr(encode(0, 0, 28, 0, FUNCT_MFHI), 0);
        add_instr(encode(0, 0, 29, 0, FUNCT_MFLO), 0);
        add_instr(encode(1, 2, 0, 0, FUNCT_MULTU), 0);
        add_instr(encode(0, 0, 30, 0, FUNCT_MFHI), 0);
        add_instr(encode(0, 0, 31, 0, FUNCT_MFLO), 1);
        add_instr(encode(3, 0, 0, 0, FUNCT_JR), 0);
        add_instr(encode(1, 2, 5, 0, FUNCT_ADDU), 0);
        add_instr(encode(4, 0, 31, 0, FUNCT_JALR), 0);
        add_instr(encode(31, 0, 6, 0, FUNCT_ADDU), 1);
        // Each exception drops the slot right after it.
        add_instr(encode(0, 0, 0, 0, FUNCT_SYSCALL), 0);
        add_instr(encode(1, 2, 7, 0, FUNCT_ADDU), 1);
        add_instr(encode(1, 2, 0, 0, 6'h1a), 0);
        add_instr(encode(1, 2, 8, 0, FUNCT_OR), 1);
        add_instr(encode(0, 0, 0, 0, 6'h3f), 0);
        add_instr(encode(1, 2, 9, 0, FUNCT_AND), 0);
        add_instr(32'h2001_0005, 0);
        add_instr(encode(1, 2, 10, 0, FUNCT_XOR), 0);
        add_instr(encode(1, 2, 11, 0, FUNCT_ADDU), 2);
    endtask

    initial begin
        logic [31:0] w;
        reset = 1'b1;
        instr_valid = 1'b0;
        instruction = 32'd0;
        pc = 32'd0;
        load_valid = 1'b0;
        load_reg = 5'd0;
        load_data = 32'd0;
        for (int i = 0; i < 32; i++) regs[i] = 32'd0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int r = 1; r < 32; r++) begin
            random_word(w);
            run_slot(1'b1, 5'(r), w, 1'b0, 32'd0);
        end
        build_table();
        foreach (table_q[i]) begin
            run_slot(table_q[i].load_en, table_q[i].load_reg, table_q[i].load_data,
                     1'b1, table_q[i].word);
            repeat (table_q[i].gap) run_slot(1'b0, 5'd0, 32'd0, 1'b0, 32'd0);
        end
        // The last two slots come out on the next two falling edges.
        while (exp_q.size() > 0) begin
            @(negedge clk);
            instr_valid = 1'b0;
            load_valid = 1'b0;
            check_slot(exp_q.pop_front());
        end
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/rtype_core_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtype_core_sva (
    input logic       clk,
    input logic       reset,
    input logic       wb_valid,
    input logic [4:0] wb_reg,
    input logic       exc_valid,
    input logic       redirect_valid
);

    wb_exc_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(wb_valid && exc_valid))
        else $error("writeback and exception raised in the same cycle");

    wb_reg_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_reg != 5'd0)
        else $error("writeback to register zero");

    // Registered outputs come out of reset low.
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !wb_valid && !exc_valid && !redirect_valid)
        else $error("outputs active in the cycle after reset");

    redirect_exc_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(redirect_valid && exc_valid))
        else $error("redirect and exception raised in the same cycle");

endmodule

`default_nettype wire

// ==== source/rtype_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtype_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instruction,
    input  logic [31:0] pc,
    input  logic        load_valid,
    input  logic [4:0]  load_reg,
    input  logic [31:0] load_data,
    output logic        wb_valid,
    output logic [4:0]  wb_reg,
    output logic [31:0] wb_data,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic        exc_valid,
    output exc_t        exc_code
);

    decode_exec_if dx ();

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instruction (instruction),
        .pc          (pc),
        .dx          (dx.decode)
    );

    execute_stage u_execute (
        .clk            (clk),
        .reset          (reset),
        .dx             (dx.execute),
        .load_valid     (load_valid),
        .load_reg       (load_reg),
        .load_data      (load_data),
        .wb_valid       (wb_valid),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .exc_valid      (exc_valid),
        .exc_code       (exc_code)
    );

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    decode_exec_if.execute dx,
    input  logic        load_valid,
    input  logic [4:0]  load_reg,
    input  logic [31:0] load_data,
    output logic        wb_valid,
    output logic [4:0]  wb_reg,
    output logic [31:0] wb_data,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic        exc_valid,
    output exc_t        exc_code
);

    logic [31:0]        rf_rs;
    logic [31:0]        rf_rt;
    logic [31:0]        rs_val;
    logic [31:0]        rt_val;
    logic [4:0]         shift_amt;
    logic [31:0]        alu_result;
    logic [31:0]        write_value;
    logic               flag_met;
    logic               write_en;
    logic signed [63:0] prod_signed;
    logic [63:0]        prod_unsigned;
    logic [63:0]        product;
    logic [31:0]        hi;
    logic [31:0]        lo;
    logic               take_exc;
    logic               take_jump;

    register_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (dx.rs),
        .rt_addr (dx.rt),
        .rs_data (rf_rs),
        .rt_data (rf_rt),
        .we_a    (wb_valid),
        .addr_a  (wb_reg),
        .data_a  (wb_data),
        .we_b    (load_valid),
        .addr_b  (load_reg),
        .data_b  (load_data)
    );

    // The previous result is still in the output register, not yet in the file.
    assign rs_val = (wb_valid && wb_reg == dx.rs && dx.rs != 5'd0) ? wb_data : rf_rs;
    assign rt_val = (wb_valid && wb_reg == dx.rt && dx.rt != 5'd0) ? wb_data : rf_rt;

    assign shift_amt = dx.ctl.use_shamt ? dx.shamt : rs_val[4:0];

    always_comb begin
        case (dx.ctl.alu_op)
            ALU_SUB:               alu_result = rs_val - rt_val;
            ALU_AND:               alu_result = rs_val & rt_val;
            ALU_OR:                alu_result = rs_val | rt_val;
            ALU_XOR:               alu_result = rs_val ^ rt_val;
            ALU_NOR:               alu_result = ~(rs_val | rt_val);
            ALU_SLT:               alu_result = {31'd0, $signed(rs_val) < $signed(rt_val)};
            ALU_SLTU:              alu_result = {31'd0, rs_val < rt_val};
            ALU_SHIFT_LEFT:        alu_result = rt_val << shift_amt;
            ALU_SHIFT_LOGIC_RIGHT: alu_result = rt_val >> shift_amt;
            ALU_ROTATE_RIGHT:
                alu_result = (rt_val >> shift_amt) | (rt_val << (6'd32 - {1'b0, shift_amt}));
            default:               alu_result = rs_val + rt_val;
        endcase
    end

    assign prod_signed   = $signed(rs_val) * $signed(rt_val);
    assign prod_unsigned = rs_val * rt_val;
    assign product       = (dx.ctl.muldiv == MULDIV_MULT) ? prod_signed : prod_unsigned;

    always_comb begin
        case (dx.ctl.reg_src)
            REG_SRC_RS:   write_value = rs_val;
            REG_SRC_HI:   write_value = hi;
            REG_SRC_LO:   write_value = lo;
            REG_SRC_LINK: write_value = dx.pc + 32'd8;
            default:      write_value = alu_result;
        endcase
    end

    // MOVZ tests rt for zero, MOVN for non-zero.
    assign flag_met = (dx.ctl.flag_sel == FLAG_EQ) ? (rt_val == 32'd0) : (rt_val != 32'd0);
    assign write_en = dx.valid && dx.ctl.write_reg && dx.rd != 5'd0 &&
                      (dx.ctl.write_cond == WRITE_ALWAYS || flag_met);

    assign take_exc  = dx.valid && dx.ctl.pc_src == PC_SRC_EXCEPTION;
    assign take_jump = dx.valid && dx.ctl.pc_src == PC_SRC_REGISTER;
    assign dx.squash = take_exc;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
            exc_valid      <= 1'b0;
            exc_code       <= EXC_NONE;
            hi             <= 32'd0;
            lo             <= 32'd0;
        end else begin
            wb_valid       <= write_en;
            redirect_valid <= take_jump;
            exc_valid      <= take_exc;
            exc_code       <= take_exc ? dx.ctl.exc : EXC_NONE;
            if (dx.valid && dx.ctl.write_hi) begin
                hi <= (dx.ctl.hilo_src == HILO_SRC_MULDIV) ? product[63:32] : rs_val;
            end
            if (dx.valid && dx.ctl.write_lo) begin
                lo <= (dx.ctl.hilo_src == HILO_SRC_MULDIV) ? product[31:0] : rs_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_reg      <= dx.rd;
        wb_data     <= write_value;
        redirect_pc <= rs_val;
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        we_a,
    input  logic [4:0]  addr_a,
    input  logic [31:0] data_a,
    input  logic        we_b,
    input  logic [4:0]  addr_b,
    input  logic [31:0] data_b
);

    logic [31:0] regs [32];

    assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else begin
            if (we_a && addr_a != 5'd0) begin
                regs[addr_a] <= data_a;
            end
            // Last assignment wins, so a load beats writeback on the same register.
            if (we_b && addr_b != 5'd0) begin
                regs[addr_b] <= data_b;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instruction,
    input  logic [31:0] pc,
    decode_exec_if.decode dx
);

    control_t ctl;

    rtype_decoder u_decoder (
        .instruction (instruction),
        .ctl         (ctl)
    );

    // The slot after a faulting instruction is dropped here.
    always_ff @(posedge clk) begin
        if (reset) begin
            dx.valid <= 1'b0;
        end else begin
            dx.valid <= instr_valid && !dx.squash;
        end
    end

    always_ff @(posedge clk) begin
        dx.ctl   <= ctl;
        dx.rs    <= instruction[25:21];
        dx.rt    <= instruction[20:16];
        dx.rd    <= instruction[15:11];
        dx.shamt <= instruction[10:6];
        dx.pc    <= pc;
    end

endmodule

`default_nettype wire

// ==== source/rtype_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtype_decoder import mips_pkg::*; (
    input  logic [31:0] instruction,
    output control_t    ctl
);

    logic [5:0] opcode;
    funct_t     funct;

    assign opcode = instruction[31:26];
    assign funct  = funct_t'(instruction[5:0]);

    always_comb begin
        ctl = CTL_DEFAULT;
        if (opcode != 6'd0) begin
            ctl.pc_src = PC_SRC_EXCEPTION;
            ctl.exc    = EXC_RESERVED;
        end else begin
            case (funct)
                FUNCT_SLL: begin
                    ctl.write_reg = 1'b1;
                    ctl.use_shamt = 1'b1;
                    ctl.alu_op    = ALU_SHIFT_LEFT;
                end

                FUNCT_SRL: begin
                    ctl.write_reg = 1'b1;
                    ctl.use_shamt = 1'b1;
                    // Bit 21 turns SRL into ROTR.
                    if (instruction[21]) begin
                        ctl.alu_op = ALU_ROTATE_RIGHT;
                    end else begin
                        ctl.alu_op = ALU_SHIFT_LOGIC_RIGHT;
                    end
                end

                FUNCT_JR: begin
                    ctl.pc_src = PC_SRC_REGISTER;
                end

                FUNCT_JALR: begin
                    ctl.pc_src    = PC_SRC_REGISTER;
                    ctl.write_reg = 1'b1;
                    ctl.reg_src   = REG_SRC_LINK;
                end

                FUNCT_MOVZ, FUNCT_MOVN: begin
                    ctl.write_reg  = 1'b1;
                    ctl.reg_src    = REG_SRC_RS;
                    ctl.write_cond = WRITE_WHEN_FLAG;
                    ctl.flag_sel   = (funct == FUNCT_MOVZ) ? FLAG_EQ : FLAG_NE;
                end

                FUNCT_SYSCALL: begin
                    ctl.pc_src = PC_SRC_EXCEPTION;
                    ctl.exc    = EXC_SYSCALL;
                end

                FUNCT_MFHI: begin
                    ctl.write_reg = 1'b1;
                    ctl.reg_src   = REG_SRC_HI;
                end

                FUNCT_MFLO: begin
                    ctl.write_reg = 1'b1;
                    ctl.reg_src   = REG_SRC_LO;
                end

                FUNCT_MTHI: begin
                    ctl.write_hi = 1'b1;
                end

                FUNCT_MTLO: begin
                    ctl.write_lo = 1'b1;
                end

                FUNCT_MULT, FUNCT_MULTU: begin
                    ctl.hilo_src = HILO_SRC_MULDIV;
                    ctl.write_hi = 1'b1;
                    ctl.write_lo = 1'b1;
                    ctl.muldiv   = (funct == FUNCT_MULT) ? MULDIV_MULT : MULDIV_MULTU;
                end

                FUNCT_ADDU, FUNCT_SUBU, FUNCT_AND, FUNCT_OR,
                FUNCT_XOR, FUNCT_NOR, FUNCT_SLT, FUNCT_SLTU: begin
                    ctl.write_reg = 1'b1;
                    case (funct)
                        FUNCT_SUBU: ctl.alu_op = ALU_SUB;
                        FUNCT_AND:  ctl.alu_op = ALU_AND;
                        FUNCT_OR:   ctl.alu_op = ALU_OR;
                        FUNCT_XOR:  ctl.alu_op = ALU_XOR;
                        FUNCT_NOR:  ctl.alu_op = ALU_NOR;
                        FUNCT_SLT:  ctl.alu_op = ALU_SLT;
                        FUNCT_SLTU: ctl.alu_op = ALU_SLTU;
                        default:    ctl.alu_op = ALU_ADD;
                    endcase
                end

                // DIV and DIVU land here as well.
                default: begin
                    ctl.pc_src = PC_SRC_EXCEPTION;
                    ctl.exc    = EXC_RESERVED;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/stage_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface decode_exec_if import mips_pkg::*; ();

    logic        valid;
    control_t    ctl;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [31:0] pc;
    // Pulsed by execute when it takes an exception.
    logic        squash;

    modport decode (
        output valid, ctl, rs, rt, rd, shamt, pc,
        input  squash
    );

    modport execute (
        input  valid, ctl, rs, rt, rd, shamt, pc,
        output squash
    );

endinterface

`default_nettype wire

// ==== source/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // Funct field of the R-type instructions in this core.
    typedef enum logic [5:0] {
        FUNCT_SLL     = 6'h00,
        FUNCT_SRL     = 6'h02,
        FUNCT_JR      = 6'h08,
        FUNCT_JALR    = 6'h09,
        FUNCT_MOVZ    = 6'h0a,
        FUNCT_MOVN    = 6'h0b,
        FUNCT_SYSCALL = 6'h0c,
        FUNCT_MFHI    = 6'h10,
        FUNCT_MTHI    = 6'h11,
        FUNCT_MFLO    = 6'h12,
        FUNCT_MTLO    = 6'h13,
        FUNCT_MULT    = 6'h18,
        FUNCT_MULTU   = 6'h19,
        FUNCT_ADDU    = 6'h21,
        FUNCT_SUBU    = 6'h23,
        FUNCT_AND     = 6'h24,
        FUNCT_OR      = 6'h25,
        FUNCT_XOR     = 6'h26,
        FUNCT_NOR     = 6'h27,
        FUNCT_SLT     = 6'h2a,
        FUNCT_SLTU    = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SHIFT_LEFT,
        ALU_SHIFT_LOGIC_RIGHT,
        ALU_ROTATE_RIGHT
    } alu_op_t;

    typedef enum logic [2:0] {
        REG_SRC_ALU,
        REG_SRC_RS,
        REG_SRC_HI,
        REG_SRC_LO,
        REG_SRC_LINK
    } reg_src_t;

    typedef enum logic [1:0] {PC_SRC_NEXT, PC_SRC_REGISTER, PC_SRC_EXCEPTION} pc_src_t;
    typedef enum logic [1:0] {EXC_NONE, EXC_SYSCALL, EXC_RESERVED} exc_t;
    typedef enum logic {HILO_SRC_RS, HILO_SRC_MULDIV} hilo_src_t;
    typedef enum logic [1:0] {MULDIV_NONE, MULDIV_MULT, MULDIV_MULTU} muldiv_t;
    typedef enum logic {WRITE_ALWAYS, WRITE_WHEN_FLAG} write_cond_t;
    typedef enum logic {FLAG_EQ, FLAG_NE} flag_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        use_shamt;
        logic        write_reg;
        reg_src_t    reg_src;
        write_cond_t write_cond;
        flag_t       flag_sel;
        logic        write_hi;
        logic        write_lo;
        hilo_src_t   hilo_src;
        muldiv_t     muldiv;
        pc_src_t     pc_src;
        exc_t        exc;
    } control_t;

    // No writes, no jump, no exception.
    localparam control_t CTL_DEFAULT = '{
        alu_op:     ALU_ADD,
        use_shamt:  1'b0,
        write_reg:  1'b0,
        reg_src:    REG_SRC_ALU,
        write_cond: WRITE_ALWAYS,
        flag_sel:   FLAG_EQ,
        write_hi:   1'b0,
        write_lo:   1'b0,
        hilo_src:   HILO_SRC_RS,
        muldiv:     MULDIV_NONE,
        pc_src:     PC_SRC_NEXT,
        exc:        EXC_NONE
    };

endpackage

`default_nettype wire
